// ==== sim.f ====
rv_pkg.sv
rv_if.sv
rv_fetch.sv
rv_regfile.sv
rv_csr.sv
rv_execute.sv
rv_bus_port.sv
riscv64.sv
tb_riscv64.sv

// ==== tb_riscv64.sv ====
`timescale 1ns/1ps

module tb_riscv64 import rv_pkg::*; ();

    // cycles each test program runs after reset
    localparam int reset_cycles     = 8;
    localparam int heartbeat_cycles = 6;
    localparam int arith_cycles     = 20;
    localparam int memory_cycles    = 20;
    localparam int control_cycles   = 30;
    localparam int interrupt_cycles = 40;
    localparam int test_cycles = 5 * (reset_cycles + 1) + heartbeat_cycles + arith_cycles +
                                 memory_cycles + control_cycles + interrupt_cycles;
    // generous margin over the expected run length
    localparam int cycle_limit = test_cycles * 5 / 2;

    logic     clk;
    logic     reset;
    instr_t   instruction;
    xword_t   pc;
    instr_t   ir;
    xword_t   regs [32];
    logic     heartbeat;
    irq_vec_t interrupt_vector;
    logic     interrupt_ack;
    xword_t   bus_address;
    xword_t   bus_write_data;
    logic     bus_write_enable;
    logic     bus_read_enable;
    xword_t   bus_read_data;

    // word-addressed program rom, trap_base lands on word 64
    instr_t      rom [128];
    // doubleword data memory, indexed by address bits 8:3
    xword_t      mem [64];
    int          errors;
    int          cycles;
    logic [31:0] rng_state;

    riscv64 i_dut (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .ir               (ir),
        .regs             (regs),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run-length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles, %0d errors", cycle_limit,
                     errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [6:0] rom_index(xword_t addr);
        xword_t offset;
        offset = addr - ram_base;
        return offset[8:2];
    endfunction

    // rom answers the new pc just after each edge
    always @(posedge clk) begin
        #1;
        instruction = rom[rom_index(pc)];
    end

    // memory takes writes from the pins and returns read data for the shown address
    always @(posedge clk) begin
        #1;
        if (bus_write_enable) begin
            mem[bus_address[8:3]] = bus_write_data;
        end
        bus_read_data = mem[bus_address[8:3]];
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // instruction encoders, field order from the base isa formats
    function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic instr_t i_type(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                      reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return i_type(op_imm, f3_add, rd, rs1, imm);
    endfunction

    function automatic instr_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3_d, imm[4:0], op_store};
    endfunction

    function automatic instr_t u_type(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic instr_t j_type(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic instr_t b_type(reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3_beq, off[4:1], off[11], op_branch};
    endfunction

    // reference model helpers, rv64 sign extension
    function automatic xword_t sext_i(logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic xword_t sext_u(logic [19:0] imm);
        return {{32{imm[19]}}, imm, 12'b0};
    endfunction

    task automatic check_value(string test, string what, xword_t expected, xword_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error in %s, %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_reg(string test, int idx, xword_t expected);
        check_value(test, $sformatf("x%0d", idx), expected, regs[idx]);
    endtask

    task automatic check_true(string test, logic cond, string message);
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s: %s", test, message);
        end
    endtask

    // advance one or more edges, leaving time just past the edge
    task automatic run_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 128; i++) begin
            rom[i] = addi(0, 0, 12'd0);
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        interrupt_vector = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
    endtask

    task automatic test_reset();
        logic prev;
        clear_memories();
        apply_reset();
        check_value("reset", "pc", ram_base, pc);
        check_value("reset", "ir", {32'd0, ir_reset}, {32'd0, ir});
        check_value("reset", "bus_read_enable", 64'd0, {63'd0, bus_read_enable});
        check_value("reset", "bus_write_enable", 64'd0, {63'd0, bus_write_enable});
        check_value("reset", "interrupt_ack", 64'd0, {63'd0, interrupt_ack});
        check_value("reset", "heartbeat", 64'd0, {63'd0, heartbeat});
        for (int i = 0; i < heartbeat_cycles; i++) begin
            prev = heartbeat;
            run_cycles(1);
            check_value("reset", "heartbeat", {63'd0, ~prev}, {63'd0, heartbeat});
        end
    endtask

    task automatic test_arith();
        logic [19:0] u1;
        logic [19:0] u2;
        logic [19:0] u3;
        logic [11:0] i1;
        logic [11:0] i2;
        logic [11:0] i3;
        xword_t      x1;
        xword_t      x2;
        u1 = 20'(random_word());
        u2 = 20'(random_word());
        u3 = 20'(random_word());
        i1 = 12'(random_word());
        i2 = 12'(random_word());
        i3 = 12'(random_word());
        clear_memories();
        rom[0]  = u_type(op_lui, 1, u1);
        rom[1]  = addi(1, 1, i1);
        rom[2]  = u_type(op_lui, 2, u2);
        rom[3]  = addi(2, 2, i2);
        rom[4]  = r_type(f7_base, 2, 1, f3_add, 3);
        rom[5]  = r_type(f7_sub, 2, 1, f3_add, 4);
        rom[6]  = r_type(f7_base, 2, 1, f3_slt, 5);
        rom[7]  = r_type(f7_base, 1, 2, f3_slt, 6);
        rom[8]  = u_type(op_auipc, 7, u3);
        // x0 target must be discarded
        rom[9]  = addi(0, 1, i3);
        rom[10] = addi(8, 0, i3);
        rom[11] = j_type(0, 21'd0);
        apply_reset();
        run_cycles(arith_cycles);
        x1 = sext_u(u1) + sext_i(i1);
        x2 = sext_u(u2) + sext_i(i2);
        check_reg("arith", 0, 64'd0);
        check_reg("arith", 1, x1);
        check_reg("arith", 2, x2);
        check_reg("arith", 3, x1 + x2);
        check_reg("arith", 4, x1 - x2);
        check_reg("arith", 5, ($signed(x1) < $signed(x2)) ? 64'd1 : 64'd0);
        check_reg("arith", 6, ($signed(x2) < $signed(x1)) ? 64'd1 : 64'd0);
        // auipc sits at word 8
        check_reg("arith", 7, ram_base + 64'd32 + sext_u(u3));
        check_reg("arith", 8, sext_i(i3));
    endtask

    task automatic test_memory();
        logic [19:0] u;
        logic [11:0] i;
        xword_t      value;
        xword_t      waddr;
        xword_t      wdata;
        xword_t      raddr;
        int          writes;
        int          reads;
        u = 20'(random_word());
        i = 12'(random_word());
        value = sext_u(u) + sext_i(i);
        clear_memories();
        rom[0] = addi(1, 0, 12'h200);
        rom[1] = u_type(op_lui, 2, u);
        rom[2] = addi(2, 2, i);
        rom[3] = s_type(2, 1, 12'd8);
        rom[4] = addi(5, 0, 12'd1);
        rom[5] = i_type(op_load, f3_d, 3, 1, 12'd8);
        // counts its own executions, then uses the loaded value
        rom[6] = addi(4, 4, 12'd1);
        rom[7] = r_type(f7_base, 4, 3, f3_add, 6);
        rom[8] = j_type(0, 21'd0);
        apply_reset();
        writes = 0;
        reads = 0;
        waddr = '0;
        wdata = '0;
        raddr = '0;
        for (int c = 0; c < memory_cycles; c++) begin
            run_cycles(1);
            if (bus_write_enable) begin
                writes++;
                waddr = bus_address;
                wdata = bus_write_data;
            end
            if (bus_read_enable) begin
                reads++;
                raddr = bus_address;
            end
        end
        check_value("memory", "write strobes", 64'd1, 64'(writes));
        check_value("memory", "write address", 64'h208, waddr);
        check_value("memory", "write data", value, wdata);
        check_value("memory", "read strobes", 64'd1, 64'(reads));
        check_value("memory", "read address", 64'h208, raddr);
        // 0x208 is doubleword 1 of the model
        check_value("memory", "stored word", value, mem[1]);
        check_reg("memory", 3, value);
        check_reg("memory", 4, 64'd1);
        check_reg("memory", 5, 64'd1);
        check_reg("memory", 6, value + 64'd1);
    endtask

    task automatic test_control();
        clear_memories();
        rom[0]  = addi(1, 0, 12'd5);
        rom[1]  = addi(2, 0, 12'd5);
        rom[2]  = b_type(1, 2, 13'd8);
        rom[3]  = addi(10, 0, 12'd1);
        rom[4]  = addi(3, 0, 12'd7);
        // not taken, falls through to word 6
        rom[5]  = b_type(1, 3, 13'd8);
        rom[6]  = addi(11, 0, 12'd2);
        rom[7]  = j_type(12, 21'd8);
        rom[8]  = addi(13, 0, 12'd3);
        rom[9]  = u_type(op_auipc, 5, 20'd0);
        rom[10] = i_type(op_jalr, 3'b000, 14, 5, 12'd16);
        rom[11] = addi(15, 0, 12'd4);
        rom[12] = addi(16, 0, 12'd5);
        rom[13] = addi(17, 0, 12'd6);
        rom[14] = j_type(0, 21'd0);
        apply_reset();
        run_cycles(control_cycles);
        check_reg("control", 3, 64'd7);
        check_reg("control", 5, ram_base + 64'd36);
        check_reg("control", 10, 64'd0);
        check_reg("control", 11, 64'd2);
        check_reg("control", 12, ram_base + 64'd32);
        check_reg("control", 13, 64'd0);
        check_reg("control", 14, ram_base + 64'd44);
        check_reg("control", 15, 64'd0);
        check_reg("control", 16, 64'd0);
        check_reg("control", 17, 64'd6);
    endtask

    task automatic test_interrupt();
        int   acks;
        int   held;
        logic at_handler;
        clear_memories();
        // each word bumps its own counter, so a lost or doubled word shows
        for (int k = 0; k < 8; k++) begin
            rom[k] = addi(reg_idx_t'(k + 1), reg_idx_t'(k + 1), 12'd1);
        end
        rom[8]  = j_type(0, 21'd0);
        rom[64] = addi(20, 0, 12'h055);
        rom[65] = addi(21, 21, 12'd1);
        rom[68] = i_type(op_system, 3'b000, 0, 0, 12'h302);
        apply_reset();
        run_cycles(3);
        interrupt_vector = irq_external;
        acks = 0;
        held = 0;
        at_handler = 1'b0;
        for (int c = 0; c < interrupt_cycles; c++) begin
            run_cycles(1);
            if (interrupt_ack) begin
                acks++;
                at_handler = (pc == trap_base);
            end
            // keep the vector up for part of the handler, MIE is clear there
            if (acks > 0) begin
                held++;
                if (held == 3) begin
                    interrupt_vector = '0;
                end
            end
        end
        check_value("interrupt", "ack pulses", 64'd1, 64'(acks));
        check_true("interrupt", at_handler, "pc was not at the trap handler when ack pulsed");
        for (int k = 1; k <= 8; k++) begin
            check_reg("interrupt", k, 64'd1);
        end
        check_reg("interrupt", 20, 64'h55);
        check_reg("interrupt", 21, 64'd1);
    endtask

    initial begin
        reset = 1'b0;
        instruction = ir_reset;
        interrupt_vector = '0;
        bus_read_data = '0;
        errors = 0;
        cycles = 0;
        rng_state = 32'hcbbe_b2cb;
        test_reset();
        test_arith();
        test_memory();
        test_control();
        test_interrupt();
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== riscv64.sv ====
`timescale 1ns/1ps

module riscv64 import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instruction,
    output xword_t   pc,
    output instr_t   ir,
    output xword_t   regs [32],
    output logic     heartbeat,
    input  irq_vec_t interrupt_vector,
    output logic     interrupt_ack,
    output xword_t   bus_address,
    output xword_t   bus_write_data,
    output logic     bus_write_enable,
    output logic     bus_read_enable,
    input  xword_t   bus_read_data
);

    fetch_if   f_if ();
    regfile_if rf_if ();
    csr_if     c_if ();
    bus_req_if b_if ();

    // ir is visible at the top for debug
    assign ir = f_if.ir;

    rv_fetch i_fetch (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .heartbeat   (heartbeat),
        .fetch       (f_if.fetch_side)
    );

    rv_regfile i_regfile (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_if.rf_side),
        .regs  (regs)
    );

    rv_csr i_csr (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .csr              (c_if.csr_side)
    );

    rv_execute i_execute (
        .clk           (clk),
        .reset         (reset),
        .fetch         (f_if.exec_side),
        .rf            (rf_if.exec_side),
        .csr           (c_if.exec_side),
        .bus           (b_if.master),
        .bus_read_data (bus_read_data)
    );

    rv_bus_port i_bus_port (
        .clk              (clk),
        .reset            (reset),
        .bus              (b_if.slave),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable)
    );

endmodule

// ==== rv_bus_port.sv ====
`timescale 1ns/1ps

module rv_bus_port import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    bus_req_if.slave bus,
    output xword_t bus_address,
    output xword_t bus_write_data,
    output logic   bus_write_enable,
    output logic   bus_read_enable
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_address      <= ram_base;
            bus_write_data   <= '0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
        end else begin
            // strobes last one cycle, no ready from the bus
            bus_write_enable <= bus.we;
            bus_read_enable  <= bus.re;
            // idle pins between requests
            if (bus.we || bus.re) begin
                bus_address <= bus.addr;
            end else begin
                bus_address <= ram_base;
            end
            // data only for stores
            if (bus.we) begin
                bus_write_data <= bus.wdata;
            end else begin
                bus_write_data <= '0;
            end
        end
    end

    // execute issues one kind of access per cycle
    assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable))
        else $error("read and write enables both high");

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    fetch_if.exec_side   fetch,
    regfile_if.exec_side rf,
    csr_if.exec_side     csr,
    bus_req_if.master    bus,
    input  xword_t bus_read_data
);

    exec_state_t state;
    exec_state_t state_next;
    // state that follows the current flush, load_done only behind ld
    exec_state_t after_flush;
    exec_state_t after_next;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    xword_t imm_u;
    xword_t imm_i;
    xword_t imm_s;
    xword_t imm_j;
    xword_t imm_b;

    xword_t alu_result;
    logic   alu_we;
    logic   is_ld;
    logic   is_sd;
    logic   jump;
    xword_t jump_target;
    xword_t load_data;

    assign opcode = fetch.ir[6:0];
    assign f3     = fetch.ir[14:12];
    assign f7     = fetch.ir[31:25];

    // register fields straight from ir
    assign rf.rs1 = fetch.ir[19:15];
    assign rf.rs2 = fetch.ir[24:20];
    assign rf.rd  = fetch.ir[11:7];

    // sign-extended immediates
    assign imm_u = {{32{fetch.ir[31]}}, fetch.ir[31:12], 12'b0};
    assign imm_i = {{52{fetch.ir[31]}}, fetch.ir[31:20]};
    assign imm_s = {{52{fetch.ir[31]}}, fetch.ir[31:25], fetch.ir[11:7]};
    assign imm_j = {{43{fetch.ir[31]}}, fetch.ir[31], fetch.ir[19:12], fetch.ir[20],
                    fetch.ir[30:21], 1'b0};
    assign imm_b = {{51{fetch.ir[31]}}, fetch.ir[31], fetch.ir[7], fetch.ir[30:25],
                    fetch.ir[11:8], 1'b0};

    assign is_ld = (opcode == op_load) && (f3 == f3_d);
    assign is_sd = (opcode == op_store) && (f3 == f3_d);

    // taken jumps and branches
    assign jump = (opcode == op_jal) || (opcode == op_jalr) ||
                  ((opcode == op_branch) && (f3 == f3_beq) && (rf.rs1_data == rf.rs2_data));

    // jalr clears bit 0, the rest are relative to the instruction itself
    always_comb begin
        if (opcode == op_jalr) begin
            jump_target = (rf.rs1_data + imm_i) & ~xword_t'(1);
        end else if (opcode == op_jal) begin
            jump_target = fetch.ir_pc + imm_j;
        end else begin
            jump_target = fetch.ir_pc + imm_b;
        end
    end

    // ALU and link results, unknown encodings write nothing
    always_comb begin
        alu_result = '0;
        alu_we     = 1'b0;
        case (opcode)
            op_lui: begin
                alu_result = imm_u;
                alu_we     = 1'b1;
            end
            op_auipc: begin
                alu_result = fetch.ir_pc + imm_u;
                alu_we     = 1'b1;
            end
            op_imm: begin
                alu_result = rf.rs1_data + imm_i;
                alu_we     = (f3 == f3_add);
            end
            op_reg: begin
                if (f3 == f3_slt) begin
                    alu_result = xword_t'($signed(rf.rs1_data) < $signed(rf.rs2_data));
                    alu_we     = (f7 == f7_base);
                end else if (f7 == f7_sub) begin
                    alu_result = rf.rs1_data - rf.rs2_data;
                    alu_we     = (f3 == f3_add);
                end else begin
                    alu_result = rf.rs1_data + rf.rs2_data;
                    alu_we     = (f3 == f3_add) && (f7 == f7_base);
                end
            end
            // link is the address after the jump
            op_jal, op_jalr: begin
                alu_result = fetch.ir_pc + 64'd4;
                alu_we     = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        fetch.redirect    = 1'b0;
        fetch.redirect_pc = trap_base;
        rf.rd_we          = 1'b0;
        rf.rd_data        = alu_result;
        bus.addr          = ram_base;
        bus.wdata         = '0;
        bus.we            = 1'b0;
        bus.re            = 1'b0;
        csr.trap_take     = 1'b0;
        csr.trap_pc       = fetch.ir_pc;
        csr.mret          = 1'b0;
        state_next        = exec_run;
        after_next        = exec_run;
        case (state)
            exec_run: begin
                if (csr.irq_pending) begin
                    // drop ir, mepc keeps its address for re-execution
                    csr.trap_take  = 1'b1;
                    fetch.redirect = 1'b1;
                    state_next     = exec_flush;
                end else if (is_ld) begin
                    // first pass, request the read and fetch ld again
                    bus.re            = 1'b1;
                    bus.addr          = rf.rs1_data + imm_i;
                    fetch.redirect    = 1'b1;
                    fetch.redirect_pc = fetch.ir_pc;
                    state_next        = exec_flush;
                    after_next        = exec_load_done;
                end else if (fetch.ir == instr_mret) begin
                    csr.mret          = 1'b1;
                    fetch.redirect    = 1'b1;
                    fetch.redirect_pc = csr.mepc;
                    state_next        = exec_flush;
                end else begin
                    rf.rd_we = alu_we;
                    // sd goes straight out, no stall
                    bus.we    = is_sd;
                    bus.addr  = is_sd ? rf.rs1_data + imm_s : ram_base;
                    bus.wdata = is_sd ? rf.rs2_data : '0;
                    if (jump) begin
                        fetch.redirect    = 1'b1;
                        fetch.redirect_pc = jump_target;
                        state_next        = exec_flush;
                    end
                end
            end
            // wrong-path word in ir, nothing issues
            exec_flush: state_next = after_flush;
            // second pass of ld, write the captured read data
            exec_load_done: begin
                rf.rd_we   = is_ld;
                rf.rd_data = load_data;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= exec_run;
            after_flush <= exec_run;
        end else begin
            state       <= state_next;
            after_flush <= after_next;
        end
    end

    // read data is valid by the edge that ends the flush cycle
    always_ff @(posedge clk) begin
        if (state == exec_flush) begin
            load_data <= bus_read_data;
        end
    end

    // every redirect source lands on an even address
    assert property (@(posedge clk) disable iff (!reset) !fetch.redirect_pc[0])
        else $error("redirect_pc misaligned");

endmodule

// ==== rv_csr.sv ====
`timescale 1ns/1ps

module rv_csr import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  irq_vec_t interrupt_vector,
    output logic     interrupt_ack,
    csr_if.csr_side  csr
);

    xword_t mstatus;
    xword_t mepc;
    xword_t mcause;

    // only the external interrupt exists, masked by mstatus.MIE
    assign csr.irq_pending = (interrupt_vector == irq_external) && mstatus[mstatus_mie];
    // return address for mret
    assign csr.mepc = mepc;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // interrupts enabled out of reset
            mstatus       <= xword_t'(64'd1 << mstatus_mie);
            mepc          <= '0;
            mcause        <= '0;
            interrupt_ack <= 1'b0;
        end else begin
            // ack follows trap entry by one edge
            interrupt_ack <= csr.trap_take;
            if (csr.trap_take) begin
                // trap entry
                mepc                  <= csr.trap_pc;
                mcause                <= mcause_ext_irq;
                mstatus[mstatus_mpie] <= mstatus[mstatus_mie];
                mstatus[mstatus_mie]  <= 1'b0;
            end else if (csr.mret) begin
                // restore MIE, MPIE goes back to one
                mstatus[mstatus_mie]  <= mstatus[mstatus_mpie];
                mstatus[mstatus_mpie] <= 1'b1;
            end
        end
    end

    // execute never traps and returns in the same cycle
    assert property (@(posedge clk) disable iff (!reset) !(csr.trap_take && csr.mret))
        else $error("trap_take and mret together");

    // mret only leaves a handler that a trap entered
    assert property (@(posedge clk) disable iff (!reset) csr.mret |-> mcause == mcause_ext_irq)
        else $error("mret without a recorded interrupt cause");

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    regfile_if.rf_side rf,
    output xword_t regs [32]
);

    // combinational reads, x0 reads as zero
    always_comb begin
        rf.rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
        rf.rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.rd_we && rf.rd != '0) begin
            // writes to x0 are dropped
            regs[rf.rd] <= rf.rd_data;
        end
    end

    // a write strobe always comes with a known index and value
    assert property (@(posedge clk) disable iff (!reset)
        rf.rd_we |-> !$isunknown({rf.rd, rf.rd_data}))
        else $error("register write with unknown index or data");

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t instruction,
    output xword_t pc,
    output logic   heartbeat,
    fetch_if.fetch_side fetch
);

    xword_t pc_next;

    // a redirect from execute wins over the sequential step
    always_comb begin
        if (fetch.redirect) begin
            pc_next = fetch.redirect_pc;
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc          <= ram_base;
            fetch.ir    <= ir_reset;
            fetch.ir_pc <= ram_base;
            heartbeat   <= 1'b0;
        end else begin
            pc          <= pc_next;
            // no stall, ir always takes the word presented for pc
            fetch.ir    <= instruction;
            // tag the captured word with its own address
            fetch.ir_pc <= pc;
            // liveness toggle
            heartbeat   <= ~heartbeat;
        end
    end

endmodule

// ==== rv_if.sv ====
`timescale 1ns/1ps

// fetch to execute, instruction and redirect
interface fetch_if import rv_pkg::*; ();
    instr_t ir;
    xword_t ir_pc;
    logic   redirect;
    xword_t redirect_pc;

    modport fetch_side (output ir, ir_pc, input redirect, redirect_pc);
    modport exec_side  (input ir, ir_pc, output redirect, redirect_pc);
endinterface

// two read ports and one write port
interface regfile_if import rv_pkg::*; ();
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xword_t   rs1_data;
    xword_t   rs2_data;
    xword_t   rd_data;
    logic     rd_we;

    modport rf_side   (input rs1, rs2, rd, rd_data, rd_we, output rs1_data, rs2_data);
    modport exec_side (output rs1, rs2, rd, rd_data, rd_we, input rs1_data, rs2_data);
endinterface

// machine csr handshake with execute
interface csr_if import rv_pkg::*; ();
    logic   irq_pending;
    xword_t mepc;
    logic   trap_take;
    xword_t trap_pc;
    logic   mret;

    modport csr_side  (output irq_pending, mepc, input trap_take, trap_pc, mret);
    modport exec_side (input irq_pending, mepc, output trap_take, trap_pc, mret);
endinterface

// one-cycle data bus request, registered by the bus port
interface bus_req_if import rv_pkg::*; ();
    xword_t addr;
    xword_t wdata;
    logic   we;
    logic   re;

    modport master (output addr, wdata, we, re);
    modport slave  (input addr, wdata, we, re);
endinterface

// ==== rv_pkg.sv ====
package rv_pkg;

    // 64-bit data, address and register value
    typedef logic [63:0] xword_t;
    // raw instruction word
    typedef logic [31:0] instr_t;
    // register index
    typedef logic [4:0]  reg_idx_t;
    // external interrupt vector
    typedef logic [3:0]  irq_vec_t;

    // reset pc and idle bus address
    localparam xword_t ram_base  = 64'h8000_0000;
    // mtvec is not writable, so the handler sits at a fixed offset
    localparam xword_t trap_base = ram_base + 64'h100;

    // vector value that requests the machine external interrupt
    localparam irq_vec_t irq_external = 4'd1;
    // interrupt bit plus cause 11
    localparam xword_t mcause_ext_irq = 64'h8000_0000_0000_000b;
    // mstatus bit positions
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    // reset value of ir, not a valid opcode so it decodes as a no-op
    localparam instr_t ir_reset = 32'h0000_0001;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 values, doubleword access for ld and sd
    localparam logic [2:0] f3_d   = 3'b011;
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;

    // funct7 for add/slt and for sub
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // full mret encoding, system opcode with funct12 0x302
    localparam instr_t instr_mret = {12'h302, 13'd0, op_system};

    // execute stage sequencing
    typedef enum logic [1:0] {
        exec_run,
        exec_flush,
        exec_load_done
    } exec_state_t;

endpackage
